/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_rv_core -o tb_rv_core
status=0
./obj_dir/tb_rv_core > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "test failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished cleanly"

/* sim.f */
src/rv_pkg.sv
src/alu.sv
src/reg_file.sv
src/control_unit.sv
src/datapath.sv
src/rv_core.sv
sim/rv_core_props.sv
sim/tb_rv_core.sv

/* sim/rv_core_props.sv */
`default_nettype none

module rv_core_props (
    input logic               clock,
    input logic               reset,
    input rv_pkg::mem_req_t   mem_req,
    input rv_pkg::seq_state_e state
);
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    // Only a fetch may follow a store strobe directly
    strobe_single: assert property (@(posedge clock) disable iff (reset)
        mem_req.strobe |=> !mem_req.strobe || ($past(mem_req.write) && !mem_req.write))
        else $error("memory strobe held for two consecutive cycles");

    write_in_memory: assert property (@(posedge clock) disable iff (reset)
        mem_req.write |-> mem_req.strobe && state == st_memory)
        else $error("write without a strobe in the memory state");

    fetch_in_fetch: assert property (@(posedge clock) disable iff (reset)
        mem_req.strobe && state != st_memory |-> state == st_fetch && !mem_req.write)
        else $error("strobe outside fetch and memory states");

endmodule

bind rv_core rv_core_props props (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .state   (state)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;
    import rv_pkg::*;

    localparam int period    = 40;
    localparam int mem_words = 4096;                // 16 KB indexed by addr[13:2]

    logic            clock;
    logic            reset;
    mem_req_t        mem_req;
    logic [xlen-1:0] mem_rdata;

    logic [31:0] mem [0:mem_words-1];               // Program and data share one array
    logic [31:0] rng;                               // xorshift state
    int          pc_emit;                           // Next free program word
    int          store_slot;                        // Next store offset above x10
    logic        program_ready;
    logic [31:0] fetch_q [$];                       // Expected fetch addresses
    int          gap_q [$];                         // Cycles until the next fetch
    mem_req_t    data_q [$];                        // Expected loads and stores in order

    rv_core #(
        .reset_pc (32'h0)
    ) dut (
        .clock     (clock),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[pc_emit] = word;
        pc_emit++;
    endtask

    task automatic store_reg(input logic [4:0] rs2);
        emit(enc_s(f3_word, 5'd10, rs2, 12'(store_slot * 4)));
        store_slot++;
    endtask

    task automatic emit_and_store(input logic [31:0] word);
        emit(word);
        store_reg(5'd3);                            // Result always lands in x3
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(enc_u(rd, hi[19:0]));
        emit(enc_i(op_imm, f3_add, rd, rd, value[11:0]));
    endtask

    // Taken branch skips the add, so each branch owns one bit of x5
    task automatic branch_probe(input logic [2:0] f3, input logic [4:0] rs1,
                                input logic [4:0] rs2, input int bit_no);
        emit(enc_b(f3, rs1, rs2, 13'd8));
        emit(enc_i(op_imm, f3_add, 5'd5, 5'd5, 12'(1 << bit_no)));
    endtask

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'h3c5a_0f96;
        end
        pc_emit    = 0;
        store_slot = 0;
        rng        = 32'h12f3_54ac;
        emit(enc_u(5'd10, 20'h00001));              // x10 = 0x1000 store area
        for (int round = 0; round < 3; round++) begin
            rng = xorshift(rng);
            a   = rng;
            rng = xorshift(rng);
            b   = rng;
            load_const(5'd1, a);
            load_const(5'd2, b);
            rng = xorshift(rng);                    // Immediates and shift amounts
            emit_and_store(enc_r(7'h00, f3_add, 5'd3, 5'd1, 5'd2));
            emit_and_store(enc_r(7'h20, f3_add, 5'd3, 5'd1, 5'd2));
            emit_and_store(enc_r(7'h00, f3_and, 5'd3, 5'd1, 5'd2));
            emit_and_store(enc_r(7'h00, f3_slt, 5'd3, 5'd1, 5'd2));
            emit_and_store(enc_i(op_imm, f3_add, 5'd3, 5'd1, rng[11:0]));
            emit_and_store(enc_i(op_imm, f3_slt, 5'd3, 5'd1, rng[23:12]));
            emit_and_store(enc_i(op_imm, f3_sll, 5'd3, 5'd1, {7'h00, rng[4:0]}));
            emit_and_store(enc_i(op_imm, f3_srl, 5'd3, 5'd1, {7'h00, rng[9:5]}));
            emit_and_store(enc_i(op_imm, f3_srl, 5'd3, 5'd1, {7'h20, rng[14:10]}));
            emit_and_store(enc_u(5'd3, rng[31:12]));
        end
        emit(enc_i(op_imm, f3_add, 5'd0, 5'd1, 12'h123));   // Writes to x0 must vanish
        emit(enc_r(7'h00, f3_add, 5'd0, 5'd1, 5'd2));
        store_reg(5'd0);
        emit(enc_u(5'd11, 20'h00002));
        emit(enc_i(op_load, f3_word, 5'd4, 5'd11, 12'h010));  // Preset word at 0x2010
        store_reg(5'd4);
        emit(enc_i(op_imm, f3_add, 5'd6, 5'd0, 12'hfff));     // x6 = -1
        branch_probe(f3_beq, 5'd1, 5'd1, 0);
        branch_probe(f3_beq, 5'd1, 5'd2, 1);
        branch_probe(f3_bne, 5'd1, 5'd2, 2);
        branch_probe(f3_bne, 5'd1, 5'd1, 3);
        branch_probe(f3_blt, 5'd1, 5'd2, 4);
        branch_probe(f3_bge, 5'd1, 5'd2, 5);
        branch_probe(f3_blt, 5'd6, 5'd0, 6);        // Signed compare of -1 against 0
        branch_probe(f3_bge, 5'd0, 5'd6, 7);
        branch_probe(f3_blt, 5'd0, 5'd6, 8);
        store_reg(5'd5);
        emit(32'h0000_0013);                        // nop
        emit(32'h0000_007f);                        // Unknown opcode
        emit(enc_j(5'd7, 21'd8));                   // Skips the next add
        emit(enc_i(op_imm, f3_add, 5'd5, 5'd5, 12'h400));
        store_reg(5'd7);                            // Link value
        store_reg(5'd5);
        emit(enc_j(5'd0, 21'd0));                   // Parks the core
    endtask

    // ISA interpreter over the built program
    function automatic void run_reference();
        logic [31:0] x [0:31];
        logic [31:0] dmem [0:mem_words-1];
        logic [31:0] pc, next_pc, ins, rs1v, rs2v, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_j;
        logic [6:0]  op, f7;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr, taken;
        int          gap;
        mem_req_t    acc;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (int i = 0; i < mem_words; i++) begin
            dmem[i] = mem[i];
        end
        pc = '0;
        for (int step = 0; step < mem_words; step++) begin
            ins     = dmem[pc[13:2]];
            op      = ins[6:0];
            rd      = ins[11:7];
            f3      = ins[14:12];
            f7      = ins[31:25];
            rs1v    = x[ins[19:15]];
            rs2v    = x[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wr      = 1'b0;
            res     = '0;
            taken   = 1'b0;
            next_pc = pc + 32'd4;
            gap     = 3;
            acc     = '0;
            case (op)
                7'd51: begin
                    wr = 1'b1;
                    if (f7 == 7'h00 && f3 == 3'd0) res = rs1v + rs2v;
                    else if (f7 == 7'h20 && f3 == 3'd0) res = rs1v - rs2v;
                    else if (f7 == 7'h00 && f3 == 3'd7) res = rs1v & rs2v;
                    else if (f7 == 7'h00 && f3 == 3'd2) res = 32'($signed(rs1v) < $signed(rs2v));
                    else wr = 1'b0;
                end
                7'd19: begin
                    wr = 1'b1;
                    if (f3 == 3'd0) res = rs1v + imm_i;
                    else if (f3 == 3'd2) res = 32'($signed(rs1v) < $signed(imm_i));
                    else if (f3 == 3'd1 && f7 == 7'h00) res = rs1v << ins[24:20];
                    else if (f3 == 3'd5 && f7 == 7'h00) res = rs1v >> ins[24:20];
                    else if (f3 == 3'd5 && f7 == 7'h20) res = $signed(rs1v) >>> ins[24:20];
                    else wr = 1'b0;
                end
                7'd3: if (f3 == 3'd2) begin
                    addr       = rs1v + imm_i;
                    res        = dmem[addr[13:2]];
                    wr         = 1'b1;
                    gap        = 5;
                    acc.strobe = 1'b1;
                    acc.addr   = addr;
                    data_q.push_back(acc);
                end
                7'd35: if (f3 == 3'd2) begin
                    addr              = rs1v + imm_s;
                    dmem[addr[13:2]]  = rs2v;
                    gap               = 4;
                    acc.strobe        = 1'b1;
                    acc.write         = 1'b1;
                    acc.addr          = addr;
                    acc.wdata         = rs2v;
                    data_q.push_back(acc);
                end
                7'd99: begin
                    if (f3 == 3'd0) taken = (rs1v == rs2v);
                    else if (f3 == 3'd1) taken = (rs1v != rs2v);
                    else if (f3 == 3'd4) taken = ($signed(rs1v) < $signed(rs2v));
                    else if (f3 == 3'd5) taken = ($signed(rs1v) >= $signed(rs2v));
                    if (taken) next_pc = pc + imm_b;
                end
                7'd55: begin
                    res = {ins[31:12], 12'd0};
                    wr  = 1'b1;
                end
                7'd111: begin
                    res     = pc + 32'd4;
                    wr      = 1'b1;
                    next_pc = pc + imm_j;
                end
                default: ;                          // Unknown only advances
            endcase
            if (wr && rd != 5'd0) x[rd] = res;
            fetch_q.push_back(pc);
            gap_q.push_back(gap);
            if (next_pc == pc) begin                // Self loop gets one more fetch
                fetch_q.push_back(pc);
                gap_q.push_back(3);
                return;
            end
            pc = next_pc;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
    end

    // One-cycle-latency memory that also owns the program image
    initial begin : memory_model
        logic [31:0] read_word;
        logic        read_pending;
        read_word     = '0;
        read_pending  = 1'b0;
        mem_rdata     = '0;
        program_ready = 1'b0;
        build_program();
        run_reference();
        program_ready = 1'b1;
        forever begin
            @(negedge clock);
            if (!reset && mem_req.strobe) begin
                if (mem_req.write) begin
                    mem[mem_req.addr[13:2]] = mem_req.wdata;
                end else begin
                    read_word    = mem[mem_req.addr[13:2]];
                    read_pending = 1'b1;
                end
            end
            @(posedge clock);
            #1;
            mem_rdata    = read_pending ? read_word : ~read_word;  // Valid one cycle only
            read_pending = 1'b0;
        end
    end

    initial begin : compare
        int       cycle;
        int       last_fetch;
        int       fk;
        int       dk;
        logic     expect_data;
        mem_req_t req;
        cycle       = 0;
        last_fetch  = 0;
        fk          = 0;
        dk          = 0;
        expect_data = 1'b0;
        wait (program_ready);
        while (fk < fetch_q.size()) begin
            @(negedge clock);
            req = mem_req;
            if (reset) begin
                check("mem_req.strobe in reset", 32'd0, 32'(req.strobe));
            end else begin
                cycle++;
                if (req.strobe && expect_data) begin
                    check("data strobe offset", 32'd3, cycle - last_fetch);
                    check("mem_req.write", 32'(data_q[dk].write), 32'(req.write));
                    check("mem_req.addr", data_q[dk].addr, req.addr);
                    if (req.write) check("mem_req.wdata", data_q[dk].wdata, req.wdata);
                    dk++;
                    expect_data = 1'b0;
                end else if (req.strobe) begin
                    check("fetch mem_req.write", 32'd0, 32'(req.write));
                    check("fetch mem_req.addr", fetch_q[fk], req.addr);
                    if (fk > 0) check("fetch gap", gap_q[fk-1], cycle - last_fetch);
                    expect_data = (gap_q[fk] != 3);
                    last_fetch  = cycle;
                    fk++;
                end
            end
        end
        $display("test passed");
        $finish;
    end

    // Twice five cycles per instruction plus reset
    initial begin : watchdog
        wait (program_ready);
        #((2 * fetch_q.size() * 5 + 4) * period);
        $display("watchdog expired before the core reached its final loop");
        $display("test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* src/alu.sv */
`default_nettype none

module alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    eq,
    output logic                    lt
);
    import rv_pkg::*;

    logic [4:0] shamt;                              // Shift amount

    assign shamt = b[4:0];

    // Flags serve branches whatever the operation
    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));          // Signed compare

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt};
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;  // Sign bit fills from the left
            alu_pass_b: result = b;                 // lui
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/control_unit.sv */
`default_nettype none

module control_unit (
    input  logic               clock,
    input  logic               reset,
    input  rv_pkg::instr_t     instr,
    input  logic               eq,
    input  logic               lt,
    output rv_pkg::seq_state_e state,
    output rv_pkg::ctrl_t      ctrl
);
    import rv_pkg::*;

    seq_state_e next_state;
    logic       taken;                              // Branch condition met
    logic       is_mem;                             // Word load or store

    always_comb begin
        case (instr.b.funct3)
            f3_beq:  taken = eq;
            f3_bne:  taken = !eq;
            f3_blt:  taken = lt;
            f3_bge:  taken = !lt;
            default: taken = 1'b0;                  // Unknown branch just falls through
        endcase
    end

    assign is_mem = (instr.i.opcode == op_load || instr.i.opcode == op_store)
                    && instr.i.funct3 == f3_word;

    always_comb begin
        case (state)
            st_fetch:   next_state = st_decode;
            st_decode:  next_state = st_execute;
            st_execute: next_state = is_mem ? st_memory : st_fetch;
            st_memory:  next_state = (instr.i.opcode == op_load) ? st_writeback : st_fetch;
            default:    next_state = st_fetch;      // Writeback always ends the instruction
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        ctrl = '0;                                  // alu_add, nothing written
        case (state)
            st_fetch:  ctrl.mem_access = !reset;    // Port stays quiet while held in reset
            st_decode: ctrl.ir_load = 1'b1;         // Fetched word arrives this cycle
            st_execute: begin
                ctrl.pc_advance = 1'b1;
                case (instr.r.opcode)
                    op_reg: begin
                        ctrl.reg_write = 1'b1;
                        case ({instr.r.funct7, instr.r.funct3})
                            {7'h00, f3_add}: ctrl.alu_op = alu_add;
                            {7'h20, f3_add}: ctrl.alu_op = alu_sub;
                            {7'h00, f3_and}: ctrl.alu_op = alu_and;
                            {7'h00, f3_slt}: ctrl.alu_op = alu_slt;
                            default:         ctrl.reg_write = 1'b0;
                        endcase
                    end
                    op_imm: begin
                        ctrl.src_b_imm = 1'b1;
                        ctrl.reg_write = 1'b1;
                        case (instr.i.funct3)
                            f3_add: ctrl.alu_op = alu_add;  // addi, also nop
                            f3_slt: ctrl.alu_op = alu_slt;  // Comparison bit straight to rd
                            f3_sll: begin
                                ctrl.alu_op    = alu_sll;
                                ctrl.reg_write = (instr.r.funct7 == 7'h00);
                            end
                            f3_srl: begin
                                // funct7 picks logical or arithmetic
                                ctrl.alu_op    = instr.r.funct7[5] ? alu_sra : alu_srl;
                                ctrl.reg_write = (instr.r.funct7 == 7'h00
                                                  || instr.r.funct7 == 7'h20);
                            end
                            default: ctrl.reg_write = 1'b0;
                        endcase
                    end
                    op_load, op_store: ctrl.src_b_imm = 1'b1;  // rs1 + offset to result reg
                    op_branch: begin
                        ctrl.pc_load_target = taken;
                        ctrl.pc_advance     = !taken;
                    end
                    op_lui: begin
                        ctrl.src_b_imm = 1'b1;
                        ctrl.alu_op    = alu_pass_b;
                        ctrl.reg_write = 1'b1;
                    end
                    op_jal: begin
                        ctrl.reg_write      = 1'b1;
                        ctrl.wb_pc_link     = 1'b1;
                        ctrl.pc_load_target = 1'b1;
                        ctrl.pc_advance     = 1'b0;
                    end
                    default: ;                      // Unknown opcode only moves the PC
                endcase
            end
            st_memory: ctrl.mem_access = 1'b1;      // Address from result register
            st_writeback: begin
                ctrl.reg_write   = 1'b1;
                ctrl.wb_from_mem = 1'b1;            // Read data valid one cycle after strobe
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/datapath.sv */
`default_nettype none

module datapath #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  rv_pkg::ctrl_t           ctrl,
    input  rv_pkg::seq_state_e      state,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] rs1_data,
    input  logic [rv_pkg::xlen-1:0] rs2_data,
    output rv_pkg::instr_t          instr,
    output logic [rv_pkg::xlen-1:0] alu_a,
    output logic [rv_pkg::xlen-1:0] alu_b,
    output logic [rv_pkg::xlen-1:0] wb_data,
    output rv_pkg::mem_req_t        mem_req
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] result_q;                      // ALU result held for the memory state
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] target;                        // Branch or jump destination
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [xlen-1:0] imm_op;                        // Immediate for the ALU B side

    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'd0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        case (instr.i.opcode)
            op_store: imm_op = imm_s;
            op_lui:   imm_op = imm_u;
            default:  imm_op = imm_i;               // ALU immediates and loads
        endcase
    end

    assign alu_a = (instr.u.opcode == op_lui) ? '0 : rs1_data;
    assign alu_b = ctrl.src_b_imm ? imm_op : rs2_data;

    assign pc_plus4 = pc + xlen'(4);
    assign target   = pc + ((instr.j.opcode == op_jal) ? imm_j : imm_b);

    always_comb begin
        if (ctrl.wb_from_mem) begin
            wb_data = mem_rdata;
        end else if (ctrl.wb_pc_link) begin
            wb_data = pc_plus4;                     // jal link, PC not yet updated
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (ctrl.pc_load_target) begin
            pc <= target;
        end else if (ctrl.pc_advance) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.ir_load) begin
            instr <= mem_rdata;                     // Read data from the fetch strobe
        end
        if (state == st_execute) begin
            result_q <= alu_result;                 // Load/store address
        end
    end

    // One port, steered by sequencer state
    assign mem_req.strobe = ctrl.mem_access;
    assign mem_req.write  = (state == st_memory) && (instr.s.opcode == op_store);
    assign mem_req.addr   = (state == st_fetch) ? pc : result_q;
    assign mem_req.wdata  = rs2_data;

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic                    clock,
    input  logic                    reset,
    input  rv_pkg::reg_addr_t       rs1,
    input  rv_pkg::reg_addr_t       rs2,
    input  rv_pkg::reg_addr_t       rd,
    input  logic                    write,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];                   // x0 has no storage

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write && rd != '0) begin       // Writes to x0 dropped
            regs[rd] <= wdata;
        end
    end

    // Combinational read ports
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* src/rv_core.sv */
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    output rv_pkg::mem_req_t        mem_req,
    input  logic [rv_pkg::xlen-1:0] mem_rdata
);
    import rv_pkg::*;

    ctrl_t           ctrl;                          // Control word for this cycle
    seq_state_e      state;
    instr_t          instr;                         // Instruction register
    logic            eq, lt;                        // ALU compare flags
    logic [xlen-1:0] alu_a, alu_b, alu_result;
    logic [xlen-1:0] rs1_data, rs2_data;
    logic [xlen-1:0] wb_data;                       // Register write-back value

    control_unit u_control_unit (
        .clock (clock),
        .reset (reset),
        .instr (instr),
        .eq    (eq),
        .lt    (lt),
        .state (state),
        .ctrl  (ctrl)
    );

    datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrl),
        .state      (state),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .instr      (instr),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .wb_data    (wb_data),
        .mem_req    (mem_req)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .eq     (eq),
        .lt     (lt)
    );

    // Register indices straight from the instruction register
    reg_file u_reg_file (
        .clock    (clock),
        .reset    (reset),
        .rs1      (instr.r.rs1),
        .rs2      (instr.r.rs2),
        .rd       (instr.r.rd),
        .write    (ctrl.reg_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;                       // Data and address width

    typedef logic [4:0] reg_addr_t;                 // Register index

    typedef enum logic [6:0] {
        op_reg    = 7'd51,                          // R-type ALU
        op_imm    = 7'd19,                          // I-type ALU and shifts
        op_load   = 7'd3,
        op_store  = 7'd35,
        op_branch = 7'd99,                          // All four branches share this one
        op_lui    = 7'd55,
        op_jal    = 7'd111
    } opcode_e;

    localparam logic [2:0] f3_add  = 3'd0;          // add, sub, addi
    localparam logic [2:0] f3_slt  = 3'd2;
    localparam logic [2:0] f3_and  = 3'd7;
    localparam logic [2:0] f3_sll  = 3'd1;
    localparam logic [2:0] f3_srl  = 3'd5;          // srli and srai, split by funct7
    localparam logic [2:0] f3_beq  = 3'd0;
    localparam logic [2:0] f3_bne  = 3'd1;
    localparam logic [2:0] f3_blt  = 3'd4;
    localparam logic [2:0] f3_bge  = 3'd5;
    localparam logic [2:0] f3_word = 3'd2;          // lw and sw

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_slt, alu_sll, alu_srl, alu_sra, alu_pass_b
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                         // imm[11:5]
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                         // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;                           // Upper 20 bits of the result
        reg_addr_t   rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, six ways to read it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_b_imm;                         // B operand from immediate, not rs2
        logic    reg_write;
        logic    wb_from_mem;                       // Write back load data
        logic    wb_pc_link;                        // Write back PC+4
        logic    pc_load_target;                    // PC takes the branch or jump target
        logic    pc_advance;                        // PC takes PC+4
        logic    ir_load;
        logic    mem_access;                        // Strobe the memory port
    } ctrl_t;

    typedef struct packed {
        logic            strobe;
        logic            write;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_writeback
    } seq_state_e;

endpackage

`default_nettype wire
